/* testbench/rv_id_cases.txt */
# pc instr rs1 rs2 ex wb fw_a fw_b | exp: op_a op_b op_c alu_op rf_we rf_waddr illegal jmp_target
# All columns hex, jmp_target only checked for JAL and JALR
100 fff30293 11 22 e0 b0 0 0 11 ffffffff 22 0 1 05 0 0
104 7ff42393 33 44 e0 b0 0 0 33 000007ff 44 3 1 07 0 0
108 40355493 55 66 e0 b0 0 0 55 00000403 66 7 1 09 0 0
10c ff862583 1000 77 e0 b0 0 0 1000 fffffff8 77 0 1 0b 0 0
110 00414083 2000 88 e0 b0 0 0 2000 00000004 88 0 1 01 0 0
114 fed72e23 3000 99 e0 b0 0 0 3000 fffffffc 99 0 0 1c 0 0
118 06f80fa3 4000 aa e0 b0 0 0 4000 0000007f aa 0 0 1f 0 0
11c 123451b7 bb cc e0 b0 0 0 0 12345000 cc 0 1 03 0 0
120 fffff237 1 2 e0 b0 0 0 0 fffff000 2 0 1 04 0 0
124 00001297 5 6 e0 b0 0 0 124 00001000 6 0 1 05 0 0
200 001000ef 7 8 e0 b0 0 0 200 4 8 0 1 01 0 a00
300 ffdff06f 9 a e0 b0 0 0 300 4 a 0 1 00 0 2fc
400 008280e7 1001 c e0 b0 0 0 400 4 c 0 1 01 0 1008
500 ffd30167 9999 d 2004 b0 1 0 500 4 d 0 1 02 0 2000
600 00208863 a1 a2 e0 b0 0 0 a1 a2 610 a 0 10 0 0
700 fe41ece3 b1 b2 e0 b0 0 0 b1 b2 6f8 e 0 19 0 0
800 0062d263 1 2 3 b0b0 2 2 b0b0 b0b0 804 d 0 04 0 0
900 009403b3 c1 c2 e1 b1 0 1 c1 e1 e1 0 1 07 0 0
904 40c58533 c3 c4 e3 b3 1 2 e3 b3 b3 1 1 0a 0 0
908 00f736b3 c5 c6 e5 b5 2 0 b5 c6 c6 4 1 0d 0 0
90c 003170b3 c7 c8 e7 b7 1 1 e7 e7 e7 9 1 01 0 0
a00 0062c5fb abc def e0 b0 0 0 abc def def 0 0 0b 1 0
a04 022081b3 d1 d2 e0 b0 0 0 d1 d2 d2 0 0 03 1 0
a08 00002063 d3 d4 e0 b0 0 0 d3 d4 d4 0 0 00 1 0

/* rv_id_stage.f */
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/rv_decoder.sv
logic/rv_operand_unit.sv
logic/rv_id_ex_register.sv
logic/rv_id_stage.sv
testbench/rv_id_ex_sva.sv
testbench/rv_id_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f rv_id_stage.f --top-module rv_id_stage_tb -o rv_id_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/rv_id_stage_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

/* testbench/rv_id_stage_tb.sv */
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module rv_id_stage_tb;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // One line of the case file
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] ex;
    logic [31:0] wb;
    logic [1:0]  fa;
    logic [1:0]  fb;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] op_c;
    logic [3:0]  alu;
    logic        we;
    logic [4:0]  waddr;
    logic        ill;
    logic [31:0] jt;
  } tb_case_t;

  logic                  clk;
  logic                  rst_n;
  if_id_t                if_id_i;
  logic                  id_ready_o;
  fw_sel_e               fw_sel_a_i;
  fw_sel_e               fw_sel_b_i;
  logic [31:0]           rf_wdata_ex_i;
  logic [31:0]           rf_wdata_wb_i;
  reg_addr_t [1:0]       rf_raddr_o;
  logic [1:0]            rf_re_o;
  logic [1:0][31:0]      rf_rdata_i;
  logic [31:0]           jmp_target_o;
  logic                  jmp_o;
  id_ex_t                id_ex_o;
  logic                  ex_ready_i;

  tb_case_t    cases[$];
  int          pending_q[$];
  int          checks;
  int          value_errs;
  int          other_errs;
  int          delivered;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] lfsr;

  rv_id_stage i_rv_id_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_i       (if_id_i),
    .id_ready_o    (id_ready_o),
    .fw_sel_a_i    (fw_sel_a_i),
    .fw_sel_b_i    (fw_sel_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .rf_raddr_o    (rf_raddr_o),
    .rf_re_o       (rf_re_o),
    .rf_rdata_i    (rf_rdata_i),
    .jmp_target_o  (jmp_target_o),
    .jmp_o         (jmp_o),
    .id_ex_o       (id_ex_o),
    .ex_ready_i    (ex_ready_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Source registers each opcode reads, illegal words read both
  function automatic logic [1:0] read_enables(input logic [31:0] instr, input logic ill);
    if (ill) begin
      return 2'b11;
    end
    case (instr[6:0])
      `OPC_LUI, `OPC_AUIPC, `OPC_JAL:   return 2'b00;
      `OPC_JALR, `OPC_LOAD, `OPC_OPIMM: return 2'b01;
      default:                          return 2'b11;
    endcase
  endfunction

  // Flags lsu_en lsu_we bch jmp implied by the major opcode
  function automatic logic [3:0] side_effects(input logic [31:0] instr, input logic ill);
    logic [6:0] opc;
    opc = instr[6:0];
    if (ill) begin
      return 4'b0000;
    end
    return {opc == `OPC_LOAD || opc == `OPC_STORE, opc == `OPC_STORE,
            opc == `OPC_BRANCH, opc == `OPC_JAL || opc == `OPC_JALR};
  endfunction

  task automatic compare_field(input string sig, input int idx,
                               input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR case %0d %s got %h exp %h", idx, sig, got, exp);
      value_errs++;
    end
  endtask

  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] col [16];
    tb_case_t    c;
    fd = $fopen("testbench/rv_id_cases.txt", "r");
    if (fd == 0) begin
      $display("Case file testbench/rv_id_cases.txt could not be opened");
      other_errs++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Comment lines start with a hash
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15]);
        if (n == 16) begin
          c = {col[0], col[1], col[2], col[3], col[4], col[5], col[6][1:0], col[7][1:0],
               col[8], col[9], col[10], col[11][3:0], col[12][0], col[13][4:0],
               col[14][0], col[15]};
          cases.push_back(c);
        end
      end
    end
    $fclose(fd);
  endtask

  // Present one instruction with its register file and bypass data
  task automatic drive_case(input tb_case_t c);
    if_id_i       = {1'b1, c.pc, c.instr};
    fw_sel_a_i    = fw_sel_e'(c.fa);
    fw_sel_b_i    = fw_sel_e'(c.fb);
    rf_rdata_i    = {c.rs2, c.rs1};
    rf_wdata_ex_i = c.ex;
    rf_wdata_wb_i = c.wb;
  endtask

  // Compare the entry leaving ID/EX with the oldest accepted case
  task automatic check_entry();
    int         idx;
    tb_case_t   c;
    logic [3:0] flags;
    if (pending_q.size() == 0) begin
      $display("ID/EX handed over an entry with no instruction pending");
      other_errs++;
    end else begin
      idx = pending_q.pop_front();
      c   = cases[idx];
      delivered++;
      compare_field("pc", idx, id_ex_o.pc, c.pc);
      compare_field("operand_a", idx, id_ex_o.operand_a, c.op_a);
      compare_field("operand_b", idx, id_ex_o.operand_b, c.op_b);
      compare_field("operand_c", idx, id_ex_o.operand_c, c.op_c);
      compare_field("alu_op", idx, 32'(id_ex_o.ctrl.alu_op), 32'(c.alu));
      compare_field("rf_we", idx, 32'(id_ex_o.ctrl.rf_we), 32'(c.we));
      compare_field("rf_waddr", idx, 32'(id_ex_o.rf_waddr), 32'(c.waddr));
      compare_field("illegal", idx, 32'(id_ex_o.illegal), 32'(c.ill));
      // Illegal words must not reach memory, branch or jump
      flags = side_effects(c.instr, c.ill);
      compare_field("lsu_en", idx, 32'(id_ex_o.ctrl.lsu_en), 32'(flags[3]));
      compare_field("lsu_we", idx, 32'(id_ex_o.ctrl.lsu_we), 32'(flags[2]));
      compare_field("bch", idx, 32'(id_ex_o.ctrl.bch), 32'(flags[1]));
      compare_field("jmp", idx, 32'(id_ex_o.ctrl.jmp), 32'(flags[0]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, back-pressure, output monitor, timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // One LFSR bit per cycle decides whether EX takes the entry
  initial begin
    lfsr       = 32'h939c_1c9a;
    ex_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      lfsr       = lfsr_step(lfsr);
      ex_ready_i = lfsr[0];
    end
  end

  always @(negedge clk) begin
    if (rst_n && id_ex_o.instr_valid && ex_ready_i) begin
      check_entry();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run stopped at cycle %0d, %0d entries never left ID/EX",
               cycle_cnt, pending_q.size());
      $display("Cases %0d, delivered %0d, checks %0d, value errors %0d, other errors %0d",
               cases.size(), delivered, checks, value_errs, other_errs + 1);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    if_id_i       = '0;
    fw_sel_a_i    = FW_REGFILE;
    fw_sel_b_i    = FW_REGFILE;
    rf_wdata_ex_i = '0;
    rf_wdata_wb_i = '0;
    rf_rdata_i    = '0;
    checks        = 0;
    value_errs    = 0;
    other_errs    = 0;
    delivered     = 0;
    cycle_cnt     = 0;
    read_cases();
    // Worst case is a few stall cycles per instruction
    cycle_limit = 4 * cases.size() + 200;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < cases.size(); i++) begin
      drive_case(cases[i]);
      // Hold the word until ID can take it
      do begin
        @(negedge clk);
      end while (!id_ready_o);
      pending_q.push_back(i);
      // Source addresses come from the rs1 and rs2 fields
      compare_field("rf_raddr_o[0]", i, 32'(rf_raddr_o[0]), 32'(cases[i].instr[19:15]));
      compare_field("rf_raddr_o[1]", i, 32'(rf_raddr_o[1]), 32'(cases[i].instr[24:20]));
      compare_field("rf_re_o", i, 32'(rf_re_o),
                    32'(read_enables(cases[i].instr, cases[i].ill)));
      if (cases[i].instr[6:0] == `OPC_JAL || cases[i].instr[6:0] == `OPC_JALR) begin
        compare_field("jmp_target_o", i, jmp_target_o, cases[i].jt);
        compare_field("jmp_o", i, 32'(jmp_o), 32'(!cases[i].ill));
      end else begin
        compare_field("jmp_o", i, 32'(jmp_o), 32'd0);
      end
      @(posedge clk);
      #2;
    end
    if_id_i.instr_valid = 1'b0;
    while (pending_q.size() != 0) @(negedge clk);
    $display("Cases %0d, delivered %0d, checks %0d, value errors %0d, other errors %0d",
             cases.size(), delivered, checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0 && cases.size() > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* testbench/rv_id_ex_sva.sv */
`timescale 1ns/1ps

module rv_id_ex_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                ex_ready_i,
  input logic                ready_o,
  input rv_pipe_pkg::id_ex_t id_ex_o
);

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX handshake properties
  ////////////////////////////////////////////////////////////////////////////

  // Held entry stays frozen while EX stalls
  property p_hold_under_stall;
    @(posedge clk) disable iff (!rst_n)
      id_ex_o.instr_valid && !ex_ready_i |=> $stable(id_ex_o);
  endproperty

  // Empty register always takes a new instruction
  property p_ready_when_empty;
    @(posedge clk) disable iff (!rst_n)
      !id_ex_o.instr_valid |-> ready_o;
  endproperty

  // Register leaves reset empty
  property p_empty_after_reset;
    @(posedge clk) $rose(rst_n) |-> !id_ex_o.instr_valid;
  endproperty

  a_hold_under_stall: assert property (p_hold_under_stall)
    else $error("ID/EX payload changed while EX stalled");
  a_ready_when_empty: assert property (p_ready_when_empty)
    else $error("ID/EX empty but ready_o low");
  a_empty_after_reset: assert property (p_empty_after_reset)
    else $error("ID/EX holds a valid entry right after reset");

endmodule

bind rv_id_ex_register rv_id_ex_sva i_rv_id_ex_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .ex_ready_i (ex_ready_i),
  .ready_o    (ready_o),
  .id_ex_o    (id_ex_o)
);

/* logic/rv_id_stage.sv */
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module rv_id_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  input  rv_pipe_pkg::if_id_t               if_id_i,
  output logic                              id_ready_o,
  input  rv_pipe_pkg::fw_sel_e              fw_sel_a_i,
  input  rv_pipe_pkg::fw_sel_e              fw_sel_b_i,
  input  logic [`XLEN-1:0]                  rf_wdata_ex_i,
  input  logic [`XLEN-1:0]                  rf_wdata_wb_i,
  output rv_pipe_pkg::reg_addr_t [1:0]      rf_raddr_o,
  output logic [1:0]                        rf_re_o,
  input  logic [1:0][`XLEN-1:0]             rf_rdata_i,
  output logic [`XLEN-1:0]                  jmp_target_o,
  output logic                              jmp_o,
  output rv_pipe_pkg::id_ex_t               id_ex_o,
  input  logic                              ex_ready_i
);
  import rv_pipe_pkg::*;

  id_ctrl_t         ctrl;
  logic             illegal;
  logic [`XLEN-1:0] operand_a;
  logic [`XLEN-1:0] operand_b;
  logic [`XLEN-1:0] operand_c;

  // Source addresses straight from the R-format view
  assign rf_raddr_o[0] = if_id_i.instr.r.rs1;
  assign rf_raddr_o[1] = if_id_i.instr.r.rs2;

  rv_decoder i_rv_decoder (
    .instr_i   (if_id_i.instr),
    .ctrl_o    (ctrl),
    .illegal_o (illegal),
    .rf_re_o   (rf_re_o)
  );

  rv_operand_unit i_rv_operand_unit (
    .if_id_i       (if_id_i),
    .ctrl_i        (ctrl),
    .fw_sel_a_i    (fw_sel_a_i),
    .fw_sel_b_i    (fw_sel_b_i),
    .rf_rdata_i    (rf_rdata_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jmp_target_o  (jmp_target_o)
  );

  rv_id_ex_register i_rv_id_ex_register (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (if_id_i.instr_valid),
    .ctrl_i      (ctrl),
    .illegal_i   (illegal),
    .pc_i        (if_id_i.pc),
    .rf_waddr_i  (if_id_i.instr.r.rd),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operand_c_i (operand_c),
    .ex_ready_i  (ex_ready_i),
    .ready_o     (id_ready_o),
    .jmp_o       (jmp_o),
    .id_ex_o     (id_ex_o)
  );

endmodule

/* logic/rv_id_ex_register.sv */
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module rv_id_ex_register (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid_i,
  input  rv_pipe_pkg::id_ctrl_t  ctrl_i,
  input  logic                   illegal_i,
  input  logic [`XLEN-1:0]       pc_i,
  input  rv_pipe_pkg::reg_addr_t rf_waddr_i,
  input  logic [`XLEN-1:0]       operand_a_i,
  input  logic [`XLEN-1:0]       operand_b_i,
  input  logic [`XLEN-1:0]       operand_c_i,
  input  logic                   ex_ready_i,
  output logic                   ready_o,
  output logic                   jmp_o,
  output rv_pipe_pkg::id_ex_t    id_ex_o
);
  import rv_pipe_pkg::*;

  logic             valid_q;
  logic             accept;
  id_ctrl_t         ctrl_q;
  logic             illegal_q;
  logic [`XLEN-1:0] pc_q;
  reg_addr_t        waddr_q;
  logic [`XLEN-1:0] op_a_q;
  logic [`XLEN-1:0] op_b_q;
  logic [`XLEN-1:0] op_c_q;

  // Free slot, or the held entry leaves this cycle
  assign ready_o = !valid_q || ex_ready_i;
  assign accept  = in_valid_i && ready_o;
  // Redirect only once the jump is taken into the pipe
  assign jmp_o   = accept && ctrl_i.jmp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (ex_ready_i) begin
      // Drained by EX with nothing behind it
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on a transfer, held under back-pressure
  always_ff @(posedge clk) begin
    if (accept) begin
      ctrl_q    <= ctrl_i;
      illegal_q <= illegal_i;
      pc_q      <= pc_i;
      waddr_q   <= rf_waddr_i;
      op_a_q    <= operand_a_i;
      op_b_q    <= operand_b_i;
      op_c_q    <= operand_c_i;
    end
  end

  assign id_ex_o = '{instr_valid: valid_q, pc: pc_q, operand_a: op_a_q, operand_b: op_b_q,
                     operand_c: op_c_q, rf_waddr: waddr_q, illegal: illegal_q, ctrl: ctrl_q};

endmodule

/* logic/rv_operand_unit.sv */
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module rv_operand_unit (
  input  rv_pipe_pkg::if_id_t        if_id_i,
  input  rv_pipe_pkg::id_ctrl_t      ctrl_i,
  input  rv_pipe_pkg::fw_sel_e       fw_sel_a_i,
  input  rv_pipe_pkg::fw_sel_e       fw_sel_b_i,
  input  logic [1:0][`XLEN-1:0]      rf_rdata_i,
  input  logic [`XLEN-1:0]           rf_wdata_ex_i,
  input  logic [`XLEN-1:0]           rf_wdata_wb_i,
  output logic [`XLEN-1:0]           operand_a_o,
  output logic [`XLEN-1:0]           operand_b_o,
  output logic [`XLEN-1:0]           operand_c_o,
  output logic [`XLEN-1:0]           jmp_target_o
);
  import rv_pipe_pkg::*;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_sel;
  logic [`XLEN-1:0] rs1_fw;
  logic [`XLEN-1:0] rs2_fw;
  logic [`XLEN-1:0] bch_target;
  logic [`XLEN-1:0] jalr_target;

  // Bypass select, register file word by default
  function automatic logic [`XLEN-1:0] fw_mux(input fw_sel_e          sel,
                                             input logic [`XLEN-1:0] rf_word,
                                             input logic [`XLEN-1:0] ex_word,
                                             input logic [`XLEN-1:0] wb_word);
    case (sel)
      FW_EX:   return ex_word;
      FW_WB:   return wb_word;
      default: return rf_word;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Immediates, all sign-extended from instr[31]
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i = {{(`XLEN-12){if_id_i.instr.i.imm_11_0[11]}}, if_id_i.instr.i.imm_11_0};
  assign imm_s = {{(`XLEN-12){if_id_i.instr.s.imm_11_5[6]}},
                  if_id_i.instr.s.imm_11_5, if_id_i.instr.s.imm_4_0};
  // B: imm[12|10:5] in the upper field, imm[4:1|11] in the lower
  assign imm_b = {{(`XLEN-12){if_id_i.instr.s.imm_11_5[6]}}, if_id_i.instr.s.imm_4_0[0],
                  if_id_i.instr.s.imm_11_5[5:0], if_id_i.instr.s.imm_4_0[4:1], 1'b0};
  assign imm_u = {if_id_i.instr.u.imm_31_12, 12'b0};
  // J: imm[20|10:1|11|19:12]
  assign imm_j = {{(`XLEN-20){if_id_i.instr.u.imm_31_12[19]}}, if_id_i.instr.u.imm_31_12[7:0],
                  if_id_i.instr.u.imm_31_12[8], if_id_i.instr.u.imm_31_12[18:9], 1'b0};

  always_comb begin
    case (ctrl_i.imm_sel)
      IMM_S:   imm_sel = imm_s;
      IMM_B:   imm_sel = imm_b;
      IMM_U:   imm_sel = imm_u;
      IMM_J:   imm_sel = imm_j;
      default: imm_sel = imm_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding and operand muxes
  ////////////////////////////////////////////////////////////////////////////

  assign rs1_fw = fw_mux(fw_sel_a_i, rf_rdata_i[0], rf_wdata_ex_i, rf_wdata_wb_i);
  assign rs2_fw = fw_mux(fw_sel_b_i, rf_rdata_i[1], rf_wdata_ex_i, rf_wdata_wb_i);

  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   operand_a_o = if_id_i.pc;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_fw;
    endcase
    case (ctrl_i.op_b_sel)
      OP_B_IMM:    operand_b_o = imm_sel;
      // Link address offset
      OP_B_PCINCR: operand_b_o = `XLEN'(4);
      default:     operand_b_o = rs2_fw;
    endcase
  end

  // Store data, or the taken target for a branch
  assign bch_target  = if_id_i.pc + imm_b;
  assign operand_c_o = ctrl_i.bch ? bch_target : rs2_fw;

  // JALR target has bit 0 forced low
  assign jalr_target  = rs1_fw + imm_i;
  assign jmp_target_o = ctrl_i.jmpr ? {jalr_target[`XLEN-1:1], 1'b0} : if_id_i.pc + imm_j;

endmodule

/* logic/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_id_defs.svh"

module rv_decoder (
  input  rv_isa_pkg::instr_u    instr_i,
  output rv_pipe_pkg::id_ctrl_t ctrl_o,
  output logic                  illegal_o,
  output logic [1:0]            rf_re_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_reg_op;
  logic       alt_ok;
  logic       arith_bad;
  alu_op_e    arith_op;
  id_ctrl_t   ctrl;
  logic       illegal;
  logic [1:0] rf_re;

  // funct fields sit at the same place in every format
  assign funct3    = instr_i.r.funct3;
  assign funct7    = instr_i.r.funct7;
  assign is_reg_op = (instr_i.r.opcode == `OPC_OP);

  ////////////////////////////////////////////////////////////////////////////
  // OP and OP-IMM arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // funct7 = 0100000 only for SUB (register form) and SRA/SRAI
  assign alt_ok = (funct3 == 3'b101) || (funct3 == 3'b000 && is_reg_op);

  // OP-IMM only carries funct7 on shifts
  assign arith_bad = (is_reg_op || funct3[1:0] == 2'b01) &&
                     !(funct7 == 7'b0000000 || (funct7 == 7'b0100000 && alt_ok));

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (is_reg_op && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Major opcode decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // ADD on register operands with I-immediate, nothing enabled
    ctrl    = '0;
    illegal = 1'b0;
    rf_re   = 2'b00;
    case (instr_i.r.opcode)
      `OPC_LUI: begin
        ctrl.op_a_sel = OP_A_ZERO;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
        ctrl.rf_we    = 1'b1;
      end
      `OPC_AUIPC: begin
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
        ctrl.rf_we    = 1'b1;
      end
      `OPC_JAL: begin
        // ALU computes the link address pc + 4
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_PCINCR;
        ctrl.imm_sel  = IMM_J;
        ctrl.rf_we    = 1'b1;
        ctrl.jmp      = 1'b1;
      end
      `OPC_JALR: begin
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_PCINCR;
        ctrl.rf_we    = 1'b1;
        ctrl.jmp      = 1'b1;
        ctrl.jmpr     = 1'b1;
        rf_re         = 2'b01;
        illegal       = (funct3 != 3'b000);
      end
      `OPC_BRANCH: begin
        ctrl.imm_sel = IMM_B;
        ctrl.bch     = 1'b1;
        rf_re        = 2'b11;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: illegal     = 1'b1;
        endcase
      end
      `OPC_LOAD: begin
        // LB LH LW LBU LHU, funct3[2] marks unsigned
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.rf_we    = 1'b1;
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_size = funct3[1:0];
        ctrl.lsu_sext = !funct3[2];
        rf_re         = 2'b01;
        illegal       = (funct3[1:0] == 2'b11) || (funct3[2:1] == 2'b11);
      end
      `OPC_STORE: begin
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_S;
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_we   = 1'b1;
        ctrl.lsu_size = funct3[1:0];
        rf_re         = 2'b11;
        illegal       = funct3[2] || (funct3[1:0] == 2'b11);
      end
      `OPC_OPIMM: begin
        ctrl.alu_op   = arith_op;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.rf_we    = 1'b1;
        rf_re         = 2'b01;
        illegal       = arith_bad;
      end
      `OPC_OP: begin
        ctrl.alu_op = arith_op;
        ctrl.rf_we  = 1'b1;
        rf_re       = 2'b11;
        illegal     = arith_bad;
      end
      default: illegal = 1'b1;
    endcase

    // Illegal: no side effects, but both sources are still read
    if (illegal) begin
      ctrl.rf_we  = 1'b0;
      ctrl.lsu_en = 1'b0;
      ctrl.lsu_we = 1'b0;
      ctrl.bch    = 1'b0;
      ctrl.jmp    = 1'b0;
      ctrl.jmpr   = 1'b0;
      rf_re       = 2'b11;
    end
  end

  assign ctrl_o    = ctrl;
  assign illegal_o = illegal;
  assign rf_re_o   = rf_re;

endmodule

/* logic/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  `include "rv_id_defs.svh"

  typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

  // Operand source from the controller bypass logic
  typedef enum logic [1:0] {
    FW_REGFILE = 2'b00,
    FW_EX      = 2'b01,
    FW_WB      = 2'b10
  } fw_sel_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  // IF/ID payload
  typedef struct packed {
    logic               instr_valid;
    logic [`XLEN-1:0]   pc;
    rv_isa_pkg::instr_u instr;
  } if_id_t;

  // Decoded control, 20 bits
  typedef struct packed {
    rv_isa_pkg::alu_op_e alu_op;
    op_a_sel_e           op_a_sel;
    op_b_sel_e           op_b_sel;
    imm_sel_e            imm_sel;
    logic                rf_we;
    logic                lsu_en;
    logic                lsu_we;
    logic [1:0]          lsu_size;
    logic                lsu_sext;
    logic                bch;
    logic                jmp;
    logic                jmpr;
  } id_ctrl_t;

  // ID/EX payload
  typedef struct packed {
    logic             instr_valid;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] operand_c;
    reg_addr_t        rf_waddr;
    logic             illegal;
    id_ctrl_t         ctrl;
  } id_ex_t;

endpackage

/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

  `include "rv_id_defs.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Instruction formats, MSB first
  ////////////////////////////////////////////////////////////////////////////

  // Register-register
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  // Register-immediate, loads, JALR
  typedef struct packed {
    logic [11:0]            imm_11_0;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_fmt_t;

  // Stores, branches use the same split with scrambled bits
  typedef struct packed {
    logic [6:0]             imm_11_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm_4_0;
    logic [6:0]             opcode;
  } s_fmt_t;

  // Upper immediate, JAL shares this layout
  typedef struct packed {
    logic [19:0]            imm_31_12;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } u_fmt_t;

  // One fetched word, several decodes
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } instr_u;

  // ALU operations, upper six are branch compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

endpackage

/* logic/rv_id_defs.svh */
`ifndef RV_ID_DEFS_SVH
`define RV_ID_DEFS_SVH

// Datapath and register file geometry
`define XLEN       32
`define REG_ADDR_W 5
`define NUM_REGS   32

// RV32I major opcodes, instr[6:0]
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011

`endif
